/* verilog/codec_cfg_pkg.sv */
// Shared definitions for the codec configuration block
// Serial frame layout, Wishbone word map, gain field prefixes
// Power-up register profiles walked by the init sequencer

package codec_cfg_pkg;

    localparam int FRAME_W  = 16;                  // Serial frame width
    localparam int INIT_LEN = 20;                  // Codec registers 0x00 to 0x13

    // Wishbone word addresses
    localparam int ADR_TX_GAIN   = 'h09;
    localparam int ADR_RX_GAIN   = 'h0a;
    localparam int ADR_RAW_FRAME = 'h3b;

    localparam logic [4:0] REG_TX_GAIN    = 5'h0a; // Codec TX gain register
    localparam logic [4:0] REG_RX_GAIN    = 5'h09; // Codec RX gain register
    localparam logic [3:0] TX_GAIN_PREFIX = 4'b0100;
    localparam logic [2:0] RX_GAIN_PREFIX = 3'b010;

    // Profile selectors for INIT_PROFILE
    localparam int PROFILE_NOINTERP = 0;
    localparam int PROFILE_2XOSC    = 1;
    localparam int PROFILE_IAMP_OFF = 2;

    typedef logic [8:0] init_entry_t;              // {write enable, value}
    typedef init_entry_t [0:INIT_LEN-1] init_table_t;

    localparam init_table_t INIT_TABLES [3] = '{
        // Direct clocking, no oscillator multiply
        {{1'b1, 8'h80}, {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b0, 8'h00}, // 4-wire serial mode
         {1'b1, 8'h00}, {1'b0, 8'h00}, {1'b1, 8'h00}, {1'b1, 8'h21}, // Osc x1, no clk div, cal
         {1'b1, 8'h4b}, {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b1, 8'h20}, // RX filter, gain on PGA
         {1'b1, 8'h81}, {1'b1, 8'h01}, {1'b0, 8'h01}, {1'b0, 8'h00}, // TX/RX twos complement
         {1'b0, 8'h84}, {1'b1, 8'h00}, {1'b0, 8'h00}, {1'b0, 8'h00}},// TX gain select
        // Doubled oscillator
        {{1'b1, 8'h80}, {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b0, 8'h00},
         {1'b1, 8'h16}, {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b1, 8'h21}, // Osc multiply on
         {1'b1, 8'h4b}, {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b1, 8'h20},
         {1'b1, 8'h41}, {1'b1, 8'h01}, {1'b0, 8'h01}, {1'b0, 8'h00}, // Interp factor 2
         {1'b0, 8'h84}, {1'b1, 8'h00}, {1'b0, 8'h00}, {1'b0, 8'h00}},
        // Internal amplifier off, RX filter bypassed
        {{1'b0, 8'h80}, {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b0, 8'h00},
         {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b1, 8'h20}, // Cal, filter off
         {1'b0, 8'h4b}, {1'b0, 8'h00}, {1'b0, 8'h00}, {1'b1, 8'h20},
         {1'b1, 8'h43}, {1'b1, 8'h03}, {1'b1, 8'h81}, {1'b0, 8'h00}, // IAMP disabled at 0x0e
         {1'b1, 8'h80}, {1'b1, 8'h00}, {1'b1, 8'h00}, {1'b0, 8'h00}}
    };

    // Write frame from register number and data byte
    function automatic logic [FRAME_W-1:0] wr_frame(input logic [4:0] reg_adr,
                                                    input logic [7:0] data);
        return {1'b0, 2'b00, reg_adr, data};     // Read flag clear
    endfunction

endpackage

/* verilog/codec_wb_regs.sv */
// Wishbone write decoder for the codec configuration port
// TX and RX gain shadows with change detection
// Builds one serial command frame per accepted write that needs it

`timescale 1ns/10ps

module codec_wb_regs #(
    parameter int WB_ADDR_WIDTH = 6,
    parameter int WB_DATA_WIDTH = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [WB_ADDR_WIDTH-1:0]         wbs_adr_i,
    input  logic [WB_DATA_WIDTH-1:0]         wbs_dat_i,
    input  logic                             wbs_we_i,
    input  logic                             wbs_stb_i,
    input  logic                             wbs_cyc_i,
    output logic                             wbs_ack_o,
    input  logic                             cmd_ready_i,
    output logic                             cmd_valid_o,
    output logic [codec_cfg_pkg::FRAME_W-1:0] cmd_frame_o
);

    import codec_cfg_pkg::*;

    typedef enum logic {
        WBS_IDLE,
        WBS_ACK
    } wbs_state_t;

    wbs_state_t wbs_state;
    logic [3:0] tx_gain;                           // Shadow of last TX gain
    logic [4:0] rx_gain;                           // Shadow of last RX gain
    logic       cmd_pend;                          // Frame to issue in ack cycle
    logic       accept;
    logic [3:0] new_tx_gain;
    logic [4:0] new_rx_gain;

    assign new_tx_gain = wbs_dat_i[31:28];
    assign new_rx_gain = wbs_dat_i[4:0];

    // Writes wait for cmd_ready, reads go through at once
    assign accept = (wbs_state == WBS_IDLE) & wbs_cyc_i & wbs_stb_i &
                    (~wbs_we_i | cmd_ready_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            wbs_state <= WBS_IDLE;
            tx_gain   <= 4'h0;
            rx_gain   <= 5'h00;
            cmd_pend  <= 1'b0;
        end else begin
            cmd_pend <= 1'b0;                      // Single ack cycle only
            case (wbs_state)
                WBS_IDLE: begin
                    if (accept) begin
                        wbs_state <= WBS_ACK;
                        if (wbs_we_i) begin
                            case (wbs_adr_i)
                                WB_ADDR_WIDTH'(ADR_TX_GAIN): begin
                                    tx_gain  <= new_tx_gain;
                                    cmd_pend <= (new_tx_gain != tx_gain);
                                end
                                WB_ADDR_WIDTH'(ADR_RX_GAIN): begin
                                    rx_gain  <= new_rx_gain;
                                    cmd_pend <= (new_rx_gain != rx_gain);
                                end
                                WB_ADDR_WIDTH'(ADR_RAW_FRAME): begin
                                    cmd_pend <= 1'b1; // Always forwarded
                                end
                                default: cmd_pend <= 1'b0; // Unknown, ack only
                            endcase
                        end
                    end
                end
                WBS_ACK: begin
                    wbs_state <= WBS_IDLE;
                end
                default: wbs_state <= WBS_IDLE;
            endcase
        end
    end

    // Frame payload, captured with the access
    always_ff @(posedge clk) begin
        if (accept) begin
            case (wbs_adr_i)
                WB_ADDR_WIDTH'(ADR_TX_GAIN):
                    cmd_frame_o <= wr_frame(REG_TX_GAIN, {TX_GAIN_PREFIX, new_tx_gain});
                WB_ADDR_WIDTH'(ADR_RX_GAIN):
                    cmd_frame_o <= wr_frame(REG_RX_GAIN, {RX_GAIN_PREFIX, new_rx_gain});
                default:
                    cmd_frame_o <= wbs_dat_i[FRAME_W-1:0]; // Raw frame as given
            endcase
        end
    end

    assign wbs_ack_o   = (wbs_state == WBS_ACK);
    assign cmd_valid_o = (wbs_state == WBS_ACK) & cmd_pend;

    // Ack is a single-cycle pulse per access
    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wbs_ack_o |=> !wbs_ack_o);

endmodule

/* verilog/codec_init_seq.sv */
// Power-up init sequencer for the codec serial port
// Walks the selected profile table, then hands the engine to the host
// Generates cmd_ready and the start pulse for the serial engine

`timescale 1ns/10ps

module codec_init_seq #(
    parameter int INIT_PROFILE = 0
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cmd_valid_i,
    input  logic [codec_cfg_pkg::FRAME_W-1:0] cmd_frame_i,
    output logic                              cmd_ready_o,
    input  logic                              spi_busy_i,
    input  logic                              spi_done_i,
    output logic                              spi_start_o,
    output logic [codec_cfg_pkg::FRAME_W-1:0] spi_frame_o,
    output logic                              init_done_o
);

    import codec_cfg_pkg::*;

    localparam int IDX_W = $clog2(INIT_LEN);
    localparam init_table_t PROFILE = INIT_TABLES[INIT_PROFILE];

    typedef enum logic [1:0] {
        SEQ_WALK,                                  // Step through table
        SEQ_WAIT,                                  // Frame in flight
        SEQ_HOST                                   // Table done, host owns engine
    } seq_state_t;

    seq_state_t  seq_state;
    logic [IDX_W-1:0] idx;                         // Current codec register
    init_entry_t entry;
    logic        last_entry;

    assign entry      = PROFILE[idx];
    assign last_entry = (idx == IDX_W'(INIT_LEN - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_state   <= SEQ_WALK;
            idx         <= '0;
            spi_start_o <= 1'b0;
        end else begin
            spi_start_o <= 1'b0;                   // Pulse by default
            case (seq_state)
                SEQ_WALK: begin
                    if (entry[8]) begin
                        spi_start_o <= 1'b1;       // Enabled entry, send it
                        seq_state   <= SEQ_WAIT;
                    end else if (last_entry) begin
                        seq_state <= SEQ_HOST;
                    end else begin
                        idx <= idx + 1'b1;         // Skip disabled entry
                    end
                end
                SEQ_WAIT: begin
                    if (spi_done_i) begin
                        if (last_entry) begin
                            seq_state <= SEQ_HOST;
                        end else begin
                            idx       <= idx + 1'b1;
                            seq_state <= SEQ_WALK;
                        end
                    end
                end
                SEQ_HOST: begin
                    spi_start_o <= cmd_valid_i;    // Host command to engine
                end
                default: seq_state <= SEQ_WALK;
            endcase
        end
    end

    // Frame mux in front of the engine
    always_ff @(posedge clk) begin
        if (seq_state == SEQ_HOST) begin
            if (cmd_valid_i) begin
                spi_frame_o <= cmd_frame_i;
            end
        end else if (seq_state == SEQ_WALK) begin
            spi_frame_o <= wr_frame(5'(idx), entry[7:0]);
        end
    end

    assign init_done_o = (seq_state == SEQ_HOST);
    // Drops with the start pulse, stays low while the frame shifts
    assign cmd_ready_o = init_done_o & ~spi_busy_i & ~spi_start_o;

    // Host commands only arrive when the path was free
    cmd_never_lost: assert property (@(posedge clk) disable iff (rst)
        cmd_valid_i |-> cmd_ready_o);

endmodule

/* verilog/codec_spi_master.sv */
// Four-wire serial shift engine for the codec control port
// Clock divider, bit counter, chip enable and done pulse
// Readback byte captured from sdo at the end of each frame

`timescale 1ns/10ps

module codec_spi_master #(
    parameter int SCLK_HALF = 2
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start_i,
    input  logic [codec_cfg_pkg::FRAME_W-1:0] frame_i,
    output logic                              busy_o,
    output logic                              done_o,
    output logic                              sclk_o,
    output logic                              sdio_o,
    output logic                              sen_n_o,
    input  logic                              sdo_i,
    output logic [7:0]                        dataout_o
);

    import codec_cfg_pkg::*;

    localparam int DIV_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
    localparam int BIT_W = $clog2(FRAME_W);

    logic [DIV_W-1:0]   div_cnt;                   // Cycles within half sclk
    logic [BIT_W-1:0]   bit_cnt;                   // Bits already shifted
    logic [FRAME_W-1:0] shreg;                     // Out on MSB, sdo in on LSB
    logic               half_end;

    assign half_end = (div_cnt == DIV_W'(SCLK_HALF - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            sen_n_o <= 1'b1;
            sclk_o  <= 1'b0;
            done_o  <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            done_o <= 1'b0;
            if (sen_n_o) begin
                sclk_o  <= 1'b0;
                div_cnt <= '0;
                bit_cnt <= '0;
                if (start_i) begin
                    sen_n_o <= 1'b0;               // Enable one cycle after start
                end
            end else if (half_end) begin
                div_cnt <= '0;
                if (!sclk_o) begin
                    sclk_o <= 1'b1;                // Rising edge at mid-bit
                end else begin
                    sclk_o  <= 1'b0;               // Bit boundary
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_W'(FRAME_W - 1)) begin
                        sen_n_o <= 1'b1;           // Frame complete
                        done_o  <= 1'b1;
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Shift register and readback byte
    always_ff @(posedge clk) begin
        if (sen_n_o) begin
            if (start_i) begin
                shreg <= frame_i;
            end
        end else if (half_end && sclk_o) begin
            shreg <= {shreg[FRAME_W-2:0], sdo_i}; // Sample sdo as sclk falls
            if (bit_cnt == BIT_W'(FRAME_W - 1)) begin
                dataout_o <= {shreg[6:0], sdo_i};
            end
        end
    end

    assign sdio_o = shreg[FRAME_W-1];
    assign busy_o = ~sen_n_o;

    // Engine is never restarted mid-frame
    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start_i |-> !busy_o);

    // No clock edges reach the codec while deselected
    sclk_quiet_idle: assert property (@(posedge clk) disable iff (rst)
        sen_n_o |-> !sclk_o);

endmodule

/* verilog/codec_cfg_top.sv */
// Codec configuration top level
// Wishbone register decoder, init sequencer and serial engine
// Exposes the codec serial pins, readback byte and init status

`timescale 1ns/10ps

module codec_cfg_top #(
    parameter int WB_ADDR_WIDTH = 6,
    parameter int WB_DATA_WIDTH = 32,
    parameter int INIT_PROFILE  = codec_cfg_pkg::PROFILE_NOINTERP,
    parameter int SCLK_HALF     = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [WB_ADDR_WIDTH-1:0] wbs_adr_i,
    input  logic [WB_DATA_WIDTH-1:0] wbs_dat_i,
    input  logic                     wbs_we_i,
    input  logic                     wbs_stb_i,
    input  logic                     wbs_cyc_i,
    output logic                     wbs_ack_o,
    output logic                     sclk_o,
    output logic                     sdio_o,
    input  logic                     sdo_i,
    output logic                     sen_n_o,
    output logic [7:0]               dataout_o,
    output logic                     init_done_o
);

    import codec_cfg_pkg::*;

    logic               cmd_valid;                 // Host command, ack cycle
    logic               cmd_ready;
    logic [FRAME_W-1:0] cmd_frame;
    logic               spi_start;
    logic               spi_busy;
    logic               spi_done;
    logic [FRAME_W-1:0] spi_frame;

    codec_wb_regs #(
        .WB_ADDR_WIDTH(WB_ADDR_WIDTH),
        .WB_DATA_WIDTH(WB_DATA_WIDTH)
    ) u_wb_regs (
        .clk        (clk),
        .rst        (rst),
        .wbs_adr_i  (wbs_adr_i),
        .wbs_dat_i  (wbs_dat_i),
        .wbs_we_i   (wbs_we_i),
        .wbs_stb_i  (wbs_stb_i),
        .wbs_cyc_i  (wbs_cyc_i),
        .wbs_ack_o  (wbs_ack_o),
        .cmd_ready_i(cmd_ready),
        .cmd_valid_o(cmd_valid),
        .cmd_frame_o(cmd_frame)
    );

    codec_init_seq #(
        .INIT_PROFILE(INIT_PROFILE)
    ) u_init_seq (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid_i(cmd_valid),
        .cmd_frame_i(cmd_frame),
        .cmd_ready_o(cmd_ready),
        .spi_busy_i (spi_busy),
        .spi_done_i (spi_done),
        .spi_start_o(spi_start),
        .spi_frame_o(spi_frame),
        .init_done_o(init_done_o)
    );

    codec_spi_master #(
        .SCLK_HALF(SCLK_HALF)
    ) u_spi_master (
        .clk      (clk),
        .rst      (rst),
        .start_i  (spi_start),
        .frame_i  (spi_frame),
        .busy_o   (spi_busy),
        .done_o   (spi_done),
        .sclk_o   (sclk_o),
        .sdio_o   (sdio_o),
        .sen_n_o  (sen_n_o),
        .sdo_i    (sdo_i),
        .dataout_o(dataout_o)
    );

endmodule

/* bench/codec_spi_model.sv */
// Behavioral codec serial port for the testbench
// 32-byte register file, frame capture and read response on sdo

`timescale 1ns/10ps

module codec_spi_model (
    input  logic        sclk_i,
    input  logic        sdio_i,
    input  logic        sen_n_i,
    output logic        sdo_o,
    output logic [15:0] frame_o,                   // Last completed frame
    output int          frame_cnt_o                // Frames completed so far
);

    logic [7:0]  regs [0:31];                      // Codec register file
    logic [15:0] sh;                               // Incoming frame bits
    logic [4:0]  bit_cnt;                          // Rising edges in this frame
    logic [7:0]  rd_sh;                            // Read data going out
    logic        rd_act;

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i] = 8'h00;
        end
        sh          = 16'h0000;
        bit_cnt     = 5'd0;
        rd_sh       = 8'h00;
        rd_act      = 1'b0;
        sdo_o       = 1'b0;
        frame_o     = 16'h0000;
        frame_cnt_o = 0;
    end

    // sdio is stable while sclk is high
    always @(posedge sclk_i) begin
        if (!sen_n_i) begin
            sh      = {sh[14:0], sdio_i};
            bit_cnt = bit_cnt + 5'd1;
            if (bit_cnt == 5'd16) begin
                bit_cnt     = 5'd0;
                frame_o     = sh;
                frame_cnt_o = frame_cnt_o + 1;
                if (!sh[15]) begin
                    regs[sh[12:8]] = sh[7:0];      // Write frame lands in register
                end
            end
        end
    end

    // Read data changes on falling sclk
    always @(negedge sclk_i) begin
        if (bit_cnt == 5'd8 && sh[7]) begin
            rd_sh  = regs[sh[4:0]];                // Flag and address just received
            rd_act = 1'b1;
        end else if (rd_act && bit_cnt > 5'd8) begin
            rd_sh = {rd_sh[6:0], 1'b0};
        end
        if (bit_cnt < 5'd8) begin
            rd_act = 1'b0;                         // Address phase or idle
        end
        sdo_o = rd_act & rd_sh[7];
    end

endmodule

/* bench/codec_cfg_tb.sv */
// Testbench for the codec configuration block
// Clock, reset, Wishbone driver, codec model, table-driven checks, watchdog

`timescale 1ns/10ps

module codec_cfg_tb;

    import codec_cfg_pkg::*;

    localparam int SCLK_HALF    = 2;
    localparam int INIT_PROFILE = PROFILE_2XOSC;
    localparam init_table_t PROFILE_TBL = INIT_TABLES[INIT_PROFILE];
    localparam logic [5:0] TX_ADR  = 6'(ADR_TX_GAIN);
    localparam logic [5:0] RX_ADR  = 6'(ADR_RX_GAIN);
    localparam logic [5:0] RAW_ADR = 6'(ADR_RAW_FRAME);

    typedef struct packed {
        logic [5:0]  adr;
        logic [31:0] dat;
        logic        we;
        logic        exp_frm;                      // Access sends a frame
        logic [15:0] frame;
        logic        chk_rd;                       // Compare dataout_o after it
        logic [7:0]  rd_byte;
        logic        b2b;                          // Next row goes without waiting
    } row_t;

    logic        clk;
    logic        rst;
    logic [5:0]  wbs_adr_i;
    logic [31:0] wbs_dat_i;
    logic        wbs_we_i;
    logic        wbs_stb_i;
    logic        wbs_cyc_i;
    logic        wbs_ack_o;
    logic        sclk_o;
    logic        sdio_o;
    logic        sdo_i;
    logic        sen_n_o;
    logic [7:0]  dataout_o;
    logic        init_done_o;
    logic [15:0] frame_cap;
    int          frame_cnt;

    row_t        rows [$];
    logic [15:0] log_q [$];                        // Frames seen on the bus
    logic [15:0] exp_q [$];                        // Frames still expected
    logic [3:0]  tx_sh = 4'h0;                     // Expected gain shadows
    logic [4:0]  rx_sh = 5'h00;
    logic [31:0] rnd;
    logic [4:0]  ri;
    init_entry_t ent;
    int          seed = 32'h9549_e8c8;
    int          checks = 0;
    int          errors = 0;
    int          ack_cnt = 0;
    int          logged_cnt = 0;
    int          frames = 0;
    int          wd_cycles = 0;

    codec_cfg_top #(
        .WB_ADDR_WIDTH(6),
        .WB_DATA_WIDTH(32),
        .INIT_PROFILE (INIT_PROFILE),
        .SCLK_HALF    (SCLK_HALF)
    ) uut (.*);

    codec_spi_model u_codec (
        .sclk_i     (sclk_o),
        .sdio_i     (sdio_o),
        .sen_n_i    (sen_n_o),
        .sdo_o      (sdo_i),
        .frame_o    (frame_cap),
        .frame_cnt_o(frame_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                    // 40 ns period
    end

    // Ack counter and frame log
    always @(negedge clk) begin
        if (wbs_ack_o) begin
            ack_cnt++;
        end
        if (frame_cnt != logged_cnt) begin
            log_q.push_back(frame_cap);
            logged_cnt++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic add_row(input logic [5:0] adr, input logic [31:0] dat, input logic we,
                           input logic exp_frm, input logic [15:0] frame,
                           input logic chk_rd, input logic [7:0] rd_byte, input logic b2b);
        rows.push_back({adr, dat, we, exp_frm, frame, chk_rd, rd_byte, b2b});
    endtask

    // Gain write, frame only when the gain differs from the last one
    task automatic add_gain_row(input logic rx, input logic [31:0] dat, input logic b2b);
        logic [15:0] frm;
        logic        chg;
        if (rx) begin
            chg   = (dat[4:0] != rx_sh);
            rx_sh = dat[4:0];
            frm   = {3'b000, REG_RX_GAIN, RX_GAIN_PREFIX, dat[4:0]};
        end else begin
            chg   = (dat[31:28] != tx_sh);
            tx_sh = dat[31:28];
            frm   = {3'b000, REG_TX_GAIN, TX_GAIN_PREFIX, dat[31:28]};
        end
        add_row(rx ? RX_ADR : TX_ADR, dat, 1'b1, chg, frm, 1'b0, 8'h00, b2b);
    endtask

    task automatic wb_access(input logic [5:0] adr, input logic [31:0] dat, input logic we);
        wbs_adr_i = adr;
        wbs_dat_i = dat;
        wbs_we_i  = we;
        wbs_stb_i = 1'b1;
        wbs_cyc_i = 1'b1;
        @(negedge clk);
        while (!wbs_ack_o) begin
            @(negedge clk);                        // Held while the engine is busy
        end
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    // Covers the 3 cycles from ack to enable, then the frame itself
    task automatic wait_idle();
        repeat (4) @(negedge clk);
        while (!sen_n_o) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_frames();
        check_value("frame count", 32'(log_q.size()), 32'(exp_q.size()));
        while (log_q.size() > 0 && exp_q.size() > 0) begin
            check_value("sdio frame", 32'(log_q.pop_front()), 32'(exp_q.pop_front()));
        end
        log_q.delete();
        exp_q.delete();
    endtask

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, DUT stopped responding", wd_cycles);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        wbs_adr_i = 6'h00;
        wbs_dat_i = 32'h0;
        wbs_we_i  = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        add_gain_row(1'b0, 32'h5000_0000, 1'b0);   // New TX gain
        add_gain_row(1'b0, 32'h5123_4567, 1'b0);   // Same TX gain, other bits differ
        add_gain_row(1'b1, 32'h0000_0013, 1'b0);
        add_gain_row(1'b1, 32'habc0_0073, 1'b0);   // Same RX gain
        add_row(TX_ADR, 32'hffff_ffff, 1'b0, 1'b0, 16'h0000, 1'b0, 8'h00, 1'b0); // Read
        add_row(RAW_ADR, 32'hdead_0c5a, 1'b1, 1'b1, 16'h0c5a, 1'b0, 8'h00, 1'b0);
        add_row(RAW_ADR, 32'h0000_8c00, 1'b1, 1'b1, 16'h8c00, 1'b1, 8'h5a, 1'b0);
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            add_gain_row(k[0], rnd, 1'b1);         // Back-to-back gains
        end
        add_row(6'h15, 32'h1234_5678, 1'b1, 1'b0, 16'h0000, 1'b0, 8'h00, 1'b0);
        for (int i = 0; i < INIT_LEN; i++) begin
            ri  = 5'(i);
            ent = PROFILE_TBL[ri];
            if (ent[8]) begin
                exp_q.push_back({3'b000, ri, ent[7:0]}); // Enabled entries only
            end
        end
        frames = exp_q.size();
        foreach (rows[j]) begin
            if (rows[j].exp_frm) begin
                frames++;
            end
        end
        wd_cycles = 2 * (frames * 16 * 2 * SCLK_HALF + 50 * rows.size());
        repeat (3) @(negedge clk);
        check_value("sen_n_o", 32'(sen_n_o), 32'd1);
        check_value("sclk_o", 32'(sclk_o), 32'd0);
        check_value("wbs_ack_o", 32'(wbs_ack_o), 32'd0);
        check_value("init_done_o", 32'(init_done_o), 32'd0);
        rst = 1'b0;
        while (!init_done_o) begin
            @(negedge clk);
        end
        compare_frames();                          // Init sequence
        foreach (rows[j]) begin
            if (rows[j].exp_frm) begin
                exp_q.push_back(rows[j].frame);
            end
            wb_access(rows[j].adr, rows[j].dat, rows[j].we);
            if (!rows[j].b2b) begin
                wait_idle();
                compare_frames();
                if (rows[j].chk_rd) begin
                    check_value("dataout_o", 32'(dataout_o), 32'(rows[j].rd_byte));
                end
            end
        end
        check_value("wbs_ack_o count", 32'(ack_cnt), 32'(rows.size()));
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/codec_cfg_pkg.sv
verilog/codec_wb_regs.sv
verilog/codec_init_seq.sv
verilog/codec_spi_master.sv
verilog/codec_cfg_top.sv
bench/codec_spi_model.sv
bench/codec_cfg_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the codec configuration testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module codec_cfg_tb -f filelist.f \
    -o codec_cfg_sim || exit 1
sim_out=$(./obj_dir/codec_cfg_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "Test completed successfully" && exit 0 || exit 1
